/* source/qft_pkg.sv */
package qft_pkg;

    // Amplitude format is signed S3.4
    localparam int AMP_W    = 8;
    localparam int FRAC_W   = 4;
    localparam int N_QUBITS = 3;
    localparam int N_STATES = 1 << N_QUBITS;

    // Wide enough for any product of two amplitudes plus one add
    localparam int PROD_W = 18;

    typedef logic signed [AMP_W-1:0]  amp_t;
    typedef amp_t [N_STATES-1:0]      state_vec_t;
    typedef logic signed [PROD_W-1:0] prod_t;

    // 1/sqrt(2) scaled by 2^FRAC_W
    localparam amp_t H_SCALE = 8'sd11;

    // Fixed rotations of the controlled phase gates
    localparam amp_t COS_PI_2 = 8'sd0;
    localparam amp_t SIN_PI_2 = 8'sd16;
    localparam amp_t COS_PI_4 = 8'sd11;
    localparam amp_t SIN_PI_4 = 8'sd11;

    // Every gate stage has the same depth
    localparam int STAGE_LAT = 2;
    // Six gate stages, then the swap and output register
    localparam int QFT_LAT   = 6 * STAGE_LAT + 1;

    localparam amp_t AMP_MAX = amp_t'((1 << (AMP_W - 1)) - 1);
    localparam amp_t AMP_MIN = amp_t'(-(1 << (AMP_W - 1)));

    // Clamp a scaled intermediate back into the amplitude range
    function automatic amp_t sat_amp(input prod_t x);
        if (x > prod_t'(AMP_MAX)) begin
            return AMP_MAX;
        end
        if (x < prod_t'(AMP_MIN)) begin
            return AMP_MIN;
        end
        return amp_t'(x);
    endfunction

endpackage

/* source/state_if.sv */
`timescale 1ns/1ps

// One state vector with its valid strobe, passed from stage to stage
interface state_if;
    import qft_pkg::*;

    logic       valid;
    state_vec_t re;
    state_vec_t im;

    // Driving stage
    modport src (
        output valid,
        output re,
        output im
    );

    // Receiving stage
    modport snk (
        input valid,
        input re,
        input im
    );

endinterface

/* source/hadamard_stage.sv */
`timescale 1ns/1ps

module hadamard_stage #(
    parameter int QUBIT = 0
) (
    input  logic clk,
    input  logic rst_n,
    state_if.snk in_s,
    state_if.src out_s
);
    import qft_pkg::*;

    localparam int MASK = 1 << QUBIT;

    logic [STAGE_LAT-1:0] valid_q;

    // Valid walks along with the data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[STAGE_LAT-2:0], in_s.valid};
        end
    end

    assign out_s.valid = valid_q[STAGE_LAT-1];

    for (genvar i = 0; i < N_STATES; i++) begin : g_amp
        // Pair partners differ only in the chosen qubit bit
        localparam int LO = i & ~MASK;
        localparam int HI = i | MASK;

        prod_t re_s_q;
        prod_t im_s_q;
        prod_t re_scaled;
        prod_t im_scaled;
        amp_t  re_q;
        amp_t  im_q;

        // Cycle 1: lower index keeps the pair sum, upper index the difference
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                re_s_q <= '0;
                im_s_q <= '0;
            end else if (i == LO) begin
                re_s_q <= prod_t'($signed(in_s.re[LO])) + prod_t'($signed(in_s.re[HI]));
                im_s_q <= prod_t'($signed(in_s.im[LO])) + prod_t'($signed(in_s.im[HI]));
            end else begin
                re_s_q <= prod_t'($signed(in_s.re[LO])) - prod_t'($signed(in_s.re[HI]));
                im_s_q <= prod_t'($signed(in_s.im[LO])) - prod_t'($signed(in_s.im[HI]));
            end
        end

        // Scale by 1/sqrt(2), floor on the shift
        assign re_scaled = (re_s_q * prod_t'(H_SCALE)) >>> FRAC_W;
        assign im_scaled = (im_s_q * prod_t'(H_SCALE)) >>> FRAC_W;

        // Cycle 2: saturate into the amplitude format
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                re_q <= '0;
                im_q <= '0;
            end else begin
                re_q <= sat_amp(re_scaled);
                im_q <= sat_amp(im_scaled);
            end
        end

        assign out_s.re[i] = re_q;
        assign out_s.im[i] = im_q;
    end

endmodule

/* source/cphase_stage.sv */
`timescale 1ns/1ps

module cphase_stage #(
    parameter int            CTRL   = 0,
    parameter int            TARGET = 1,
    parameter qft_pkg::amp_t COS_K  = qft_pkg::COS_PI_2,
    parameter qft_pkg::amp_t SIN_K  = qft_pkg::SIN_PI_2
) (
    input  logic clk,
    input  logic rst_n,
    state_if.snk in_s,
    state_if.src out_s
);
    import qft_pkg::*;

    // Phase applies only where both control and target bits are one
    localparam int CT_MASK = (1 << CTRL) | (1 << TARGET);

    logic [STAGE_LAT-1:0] valid_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_q <= '0;
        end else begin
            valid_q <= {valid_q[STAGE_LAT-2:0], in_s.valid};
        end
    end

    assign out_s.valid = valid_q[STAGE_LAT-1];

    for (genvar i = 0; i < N_STATES; i++) begin : g_amp
        amp_t re_q;
        amp_t im_q;

        if ((i & CT_MASK) == CT_MASK) begin : g_rot
            prod_t re_cos_q;
            prod_t im_sin_q;
            prod_t re_sin_q;
            prod_t im_cos_q;
            prod_t re_rot;
            prod_t im_rot;

            // Cycle 1: the four partial products of the complex multiply
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    re_cos_q <= '0;
                    im_sin_q <= '0;
                    re_sin_q <= '0;
                    im_cos_q <= '0;
                end else begin
                    re_cos_q <= prod_t'($signed(in_s.re[i])) * prod_t'(COS_K);
                    im_sin_q <= prod_t'($signed(in_s.im[i])) * prod_t'(SIN_K);
                    re_sin_q <= prod_t'($signed(in_s.re[i])) * prod_t'(SIN_K);
                    im_cos_q <= prod_t'($signed(in_s.im[i])) * prod_t'(COS_K);
                end
            end

            // Combine first, then a single flooring shift
            assign re_rot = (re_cos_q - im_sin_q) >>> FRAC_W;
            assign im_rot = (re_sin_q + im_cos_q) >>> FRAC_W;

            // Cycle 2
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    re_q <= '0;
                    im_q <= '0;
                end else begin
                    re_q <= sat_amp(re_rot);
                    im_q <= sat_amp(im_rot);
                end
            end
        end else begin : g_pass
            amp_t re_d_q;
            amp_t im_d_q;

            // Untouched amplitude, delayed to line up with the rotated ones
            always_ff @(posedge clk or negedge rst_n) begin
                if (!rst_n) begin
                    re_d_q <= '0;
                    im_d_q <= '0;
                    re_q   <= '0;
                    im_q   <= '0;
                end else begin
                    re_d_q <= in_s.re[i];
                    im_d_q <= in_s.im[i];
                    re_q   <= re_d_q;
                    im_q   <= im_d_q;
                end
            end
        end

        assign out_s.re[i] = re_q;
        assign out_s.im[i] = im_q;
    end

endmodule

/* source/qft3_top.sv */
`timescale 1ns/1ps

module qft3_top (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                valid_i,
    input  qft_pkg::state_vec_t re_i,
    input  qft_pkg::state_vec_t im_i,
    output logic                valid_o,
    output qft_pkg::state_vec_t re_o,
    output qft_pkg::state_vec_t im_o
);
    import qft_pkg::*;

    // Exchange bits 0 and 2 of a basis index
    function automatic int swap_q0_q2(input int idx);
        return ((idx & 1) << 2) | (idx & 2) | ((idx >> 2) & 1);
    endfunction

    // Links between the gate stages, st0 is the input side
    state_if st0 ();
    state_if st1 ();
    state_if st2 ();
    state_if st3 ();
    state_if st4 ();
    state_if st5 ();
    state_if st6 ();

    assign st0.valid = valid_i;
    assign st0.re    = re_i;
    assign st0.im    = im_i;

    // Hadamard on q2
    hadamard_stage #(
        .QUBIT (2)
    ) u_h2 (
        .clk   (clk),
        .rst_n (rst_n),
        .in_s  (st0),
        .out_s (st1)
    );

    // Controlled phase pi/2, q1 onto q2
    cphase_stage #(
        .CTRL   (1),
        .TARGET (2),
        .COS_K  (COS_PI_2),
        .SIN_K  (SIN_PI_2)
    ) u_cp12 (
        .clk   (clk),
        .rst_n (rst_n),
        .in_s  (st1),
        .out_s (st2)
    );

    // Controlled phase pi/4, q0 onto q2
    cphase_stage #(
        .CTRL   (0),
        .TARGET (2),
        .COS_K  (COS_PI_4),
        .SIN_K  (SIN_PI_4)
    ) u_cp02 (
        .clk   (clk),
        .rst_n (rst_n),
        .in_s  (st2),
        .out_s (st3)
    );

    // Hadamard on q1
    hadamard_stage #(
        .QUBIT (1)
    ) u_h1 (
        .clk   (clk),
        .rst_n (rst_n),
        .in_s  (st3),
        .out_s (st4)
    );

    // Controlled phase pi/2, q0 onto q1
    cphase_stage #(
        .CTRL   (0),
        .TARGET (1),
        .COS_K  (COS_PI_2),
        .SIN_K  (SIN_PI_2)
    ) u_cp01 (
        .clk   (clk),
        .rst_n (rst_n),
        .in_s  (st4),
        .out_s (st5)
    );

    // Hadamard on q0
    hadamard_stage #(
        .QUBIT (0)
    ) u_h0 (
        .clk   (clk),
        .rst_n (rst_n),
        .in_s  (st5),
        .out_s (st6)
    );

    // Output register with the q0/q2 swap folded into the indexing
    // 1<->4 and 3<->6, the rest stay put
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_o <= 1'b0;
            re_o    <= '0;
            im_o    <= '0;
        end else begin
            valid_o <= st6.valid;
            for (int i = 0; i < N_STATES; i++) begin
                re_o[i] <= st6.re[swap_q0_q2(i)];
                im_o[i] <= st6.im[swap_q0_q2(i)];
            end
        end
    end

endmodule

/* sim/qft3_checker.sv */
`timescale 1ns/1ps

module qft3_checker (
    input logic                clk,
    input logic                rst_n,
    input logic                valid_i,
    input logic                valid_o,
    input qft_pkg::state_vec_t re_o,
    input qft_pkg::state_vec_t im_o
);
    import qft_pkg::*;

    // Every accepted vector leaves exactly QFT_LAT cycles later
    a_valid_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        valid_o == $past(valid_i, QFT_LAT)
    ) else $error("valid_o is not valid_i delayed by the pipeline latency");

    a_valid_in_reset: assert property (
        @(posedge clk) !rst_n |-> !valid_o
    ) else $error("valid_o high while reset is asserted");

    // Outputs still hold their reset value in the first cycle out of reset
    a_zero_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> (re_o == '0) && (im_o == '0)
    ) else $error("outputs not zero right after reset release");

endmodule

/* sim/qft3_tb.sv */
`timescale 1ns/1ps

module qft3_tb;
    import qft_pkg::*;

    localparam int RST_CYCLES = 5;
    localparam int N_STREAM   = 200;
    localparam int N_BUBBLE   = 120;
    localparam int N_SAT      = 60;
    // Four tests, each followed by a pipeline drain
    localparam int MAX_CYCLES = RST_CYCLES + N_STATES + N_STREAM + N_BUBBLE + N_SAT
                              + 4 * (QFT_LAT + 4) + 100;

    logic        clk;
    logic        rst_n;
    logic        valid_i;
    state_vec_t  re_i;
    state_vec_t  im_i;
    logic        valid_o;
    state_vec_t  re_o;
    state_vec_t  im_o;
    logic [31:0] lfsr_state;
    int          cycle;
    int          errors;
    string       test_name;

    // Working copy of the vector inside the model
    int m_re [N_STATES];
    int m_im [N_STATES];

    state_vec_t exp_re_q [$];
    state_vec_t exp_im_q [$];
    int         due_q [$];

    qft3_top u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (valid_i),
        .re_i    (re_i),
        .im_i    (im_i),
        .valid_o (valid_o),
        .re_o    (re_o),
        .im_o    (im_o)
    );

    bind qft3_top qft3_checker u_checker (
        .clk     (clk),
        .rst_n   (rst_n),
        .valid_i (valid_i),
        .valid_o (valid_o),
        .re_o    (re_o),
        .im_o    (im_o)
    );

    always #4 clk = ~clk;

    // Galois LFSR, x^32 + x^22 + x^2 + x + 1
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return b;
    endfunction

    function automatic int rand_bits(input int n);
        int v;
        v = 0;
        for (int k = 0; k < n; k++) begin
            v = (v << 1) | int'(lfsr_bit());
        end
        return v;
    endfunction

    function automatic int clamp_amp(input int x);
        if (x > 127) begin
            return 127;
        end
        if (x < -128) begin
            return -128;
        end
        return x;
    endfunction

    // Swapping q0 and q2 reverses the three index bits
    function automatic int reverse_index(input int i);
        int r;
        r = 0;
        for (int b = 0; b < N_QUBITS; b++) begin
            r = r | (((i >> b) & 1) << (N_QUBITS - 1 - b));
        end
        return r;
    endfunction

    task automatic model_hadamard(input int q);
        int hi;
        int s;
        int d;
        for (int i = 0; i < N_STATES; i++) begin
            if (((i >> q) & 1) == 0) begin
                hi = i | (1 << q);
                s = m_re[i] + m_re[hi];
                d = m_re[i] - m_re[hi];
                m_re[i]  = clamp_amp((s * int'(H_SCALE)) >>> FRAC_W);
                m_re[hi] = clamp_amp((d * int'(H_SCALE)) >>> FRAC_W);
                s = m_im[i] + m_im[hi];
                d = m_im[i] - m_im[hi];
                m_im[i]  = clamp_amp((s * int'(H_SCALE)) >>> FRAC_W);
                m_im[hi] = clamp_amp((d * int'(H_SCALE)) >>> FRAC_W);
            end
        end
    endtask

    task automatic model_cphase(input int c, input int t, input amp_t cs, input amp_t sn);
        int r;
        int m;
        for (int i = 0; i < N_STATES; i++) begin
            if (((i >> c) & 1) == 1 && ((i >> t) & 1) == 1) begin
                r = m_re[i];
                m = m_im[i];
                m_re[i] = clamp_amp((r * int'(cs) - m * int'(sn)) >>> FRAC_W);
                m_im[i] = clamp_amp((r * int'(sn) + m * int'(cs)) >>> FRAC_W);
            end
        end
    endtask

    task automatic push_expected(input state_vec_t re, input state_vec_t im);
        state_vec_t ore;
        state_vec_t oim;
        for (int i = 0; i < N_STATES; i++) begin
            m_re[i] = int'(re[i]);
            m_im[i] = int'(im[i]);
        end
        model_hadamard(2);
        model_cphase(1, 2, COS_PI_2, SIN_PI_2);
        model_cphase(0, 2, COS_PI_4, SIN_PI_4);
        model_hadamard(1);
        model_cphase(0, 1, COS_PI_2, SIN_PI_2);
        model_hadamard(0);
        for (int i = 0; i < N_STATES; i++) begin
            ore[i] = amp_t'(m_re[reverse_index(i)]);
            oim[i] = amp_t'(m_im[reverse_index(i)]);
        end
        exp_re_q.push_back(ore);
        exp_im_q.push_back(oim);
    endtask

    task automatic stop_on_error();
        $display("Done: errors found");
        $fatal(1);
    endtask

    task automatic check_vec(input string what, input state_vec_t exp, input state_vec_t act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %h, actual %h", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("ERR %s %s: expected %b, actual %b", test_name, what, exp, act);
            stop_on_error();
        end
    endtask

    task automatic drive_vec(input logic v, input state_vec_t re, input state_vec_t im);
        @(posedge clk);
        #1;
        valid_i = v;
        re_i    = re;
        im_i    = im;
    endtask

    // bits = 6 keeps amplitudes near -2.0 .. 2.0, bits = 8 spans the full range
    task automatic random_vec(input int bits, output state_vec_t re, output state_vec_t im);
        for (int i = 0; i < N_STATES; i++) begin
            re[i] = amp_t'(rand_bits(bits) - (1 << (bits - 1)));
            im[i] = amp_t'(rand_bits(bits) - (1 << (bits - 1)));
        end
    endtask

    task automatic flush_pipeline();
        drive_vec(1'b0, '0, '0);
        while (due_q.size() != 0) begin
            @(posedge clk);
        end
        repeat (2) @(posedge clk);
    endtask

    // Inputs change 1 ns after the edge, so they are stable here
    always @(posedge clk) begin
        cycle = cycle + 1;
        if (rst_n && valid_i) begin
            push_expected(re_i, im_i);
            // Last of the QFT_LAT registers loads QFT_LAT - 1 edges after this one
            due_q.push_back(cycle + QFT_LAT - 1);
        end
        if (cycle > MAX_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            stop_on_error();
        end
    end

    // Outputs are undefined before the first clock edge
    always @(negedge clk) begin
        logic exp_v;
        if (cycle > 0) begin
            if (valid_o && exp_re_q.size() == 0) begin
                $display("An output vector came out with no input vector waiting for it");
                stop_on_error();
            end
            exp_v = (due_q.size() > 0) && (due_q[0] == cycle);
            check_bit("valid_o", exp_v, valid_o);
            if (valid_o) begin
                check_vec("re_o", exp_re_q.pop_front(), re_o);
                check_vec("im_o", exp_im_q.pop_front(), im_o);
                void'(due_q.pop_front());
            end
        end
    end

    initial begin
        state_vec_t vr;
        state_vec_t vi;
        clk        = 1'b0;
        rst_n      = 1'b1;
        valid_i    = 1'b0;
        re_i       = '0;
        im_i       = '0;
        lfsr_state = 32'hc2679ea3;
        cycle      = 0;
        errors     = 0;
        test_name  = "reset";
        #1;
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge clk);
        #1;
        check_vec("re_o in reset", '0, re_o);
        check_vec("im_o in reset", '0, im_o);
        rst_n = 1'b1;
        @(negedge clk);
        check_vec("re_o after reset", '0, re_o);
        check_vec("im_o after reset", '0, im_o);

        // One real amplitude of 1.0 per vector
        test_name = "basis";
        for (int k = 0; k < N_STATES; k++) begin
            vr    = '0;
            vi    = '0;
            vr[k] = amp_t'(16);
            drive_vec(1'b1, vr, vi);
        end
        flush_pipeline();

        test_name = "stream";
        repeat (N_STREAM) begin
            random_vec(6, vr, vi);
            drive_vec(1'b1, vr, vi);
        end
        flush_pipeline();

        test_name = "bubbles";
        repeat (N_BUBBLE) begin
            random_vec(6, vr, vi);
            drive_vec(lfsr_bit(), vr, vi);
        end
        flush_pipeline();

        test_name = "saturation";
        repeat (N_SAT) begin
            random_vec(8, vr, vi);
            vr[rand_bits(3)] = amp_t'(127);
            vi[rand_bits(3)] = amp_t'(-128);
            drive_vec(1'b1, vr, vi);
        end
        flush_pipeline();

        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

/* compile.f */
source/qft_pkg.sv
source/state_if.sv
source/hadamard_stage.sv
source/cphase_stage.sv
source/qft3_top.sv
sim/qft3_checker.sv
sim/qft3_tb.sv

/* Makefile */
TOP := qft3_tb

.PHONY: all run lint clean

all: run

# Pass or fail is decided by the pass message in the simulation output
run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f compile.f -o sim_$(TOP)
	@out="$$(./obj_dir/sim_$(TOP))"; echo "$$out"; \
		echo "$$out" | grep -q "Done: no errors"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir
